//--- design/sqrt_consts.svh
`ifndef SQRT_CONSTS_SVH
`define SQRT_CONSTS_SVH

`define FLOAT_WIDTH 32
`define DEST_WIDTH  5
`define EXP_WIDTH   10

// 24 significand bits plus guard and round
`define ROOT_BITS   26
`define EXP_BIAS    127

`define FLOAT_QNAN  32'h7FC00000
`define FLOAT_PINF  32'h7F800000

`define SPEC_NORMAL 2'd0
`define SPEC_ZERO   2'd1
`define SPEC_INF    2'd2
`define SPEC_NAN    2'd3

`endif

//--- design/sqrt_pkg.sv
`include "sqrt_consts.svh"

package sqrt_pkg;

    typedef logic [`FLOAT_WIDTH-1:0] float_t;

    typedef logic [`DEST_WIDTH-1:0] dest_t;

    // unbiased, two's complement
    typedef logic signed [`EXP_WIDTH-1:0] exp_t;

    // two radicand bits per root bit
    typedef logic [2*`ROOT_BITS-1:0] rad_t;

    typedef logic [`ROOT_BITS-1:0] root_t;

    // normal, zero, infinity or nan
    typedef logic [1:0] special_t;

    typedef enum logic [1:0] {
        iter_idle,
        iter_busy,
        iter_done
    } iter_state_t;

endpackage

//--- design/sqrt_unpack.sv
`timescale 1ns/1ps

`include "sqrt_consts.svh"

module sqrt_unpack
    import sqrt_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  float_t   in_operand,
    input  dest_t    in_dest,

    output logic     u_valid,
    input  logic     u_ready,
    output rad_t     u_rad,
    output exp_t     u_exp,
    output logic     u_sign,
    output special_t u_special,
    output logic     u_invalid,
    output dest_t    u_dest
);

    logic        sign;
    logic [7:0]  exp_field;
    logic [22:0] frac;
    logic        subnormal;
    logic [4:0]  lz;
    logic [23:0] sig;
    logic [24:0] sig_even;
    exp_t        exp_unb;
    special_t    special;
    logic        invalid;
    logic        load;

    assign sign      = in_operand[`FLOAT_WIDTH-1];
    assign exp_field = in_operand[30:23];
    assign frac      = in_operand[22:0];
    assign subnormal = (exp_field == 8'h00);

    always_comb begin
        lz = 5'd0;
        for (int i = 0; i < 23; i++) begin
            if (frac[i]) lz = 5'(22 - i); // highest set bit wins
        end
    end

    assign sig = subnormal ? 24'({1'b0, frac} << (lz + 5'd1)) : {1'b1, frac};
    assign exp_unb = subnormal ? exp_t'(-`EXP_BIAS) - exp_t'({5'b0, lz})
                               : exp_t'({2'b00, exp_field}) - exp_t'(`EXP_BIAS);
    assign sig_even = exp_unb[0] ? {sig, 1'b0} : {1'b0, sig}; // shift left on odd exponent

    always_comb begin
        special = `SPEC_NORMAL;
        invalid = 1'b0;
        if (exp_field == 8'hff) begin
            if (frac != 23'd0) begin
                special = `SPEC_NAN;
                invalid = ~frac[22]; // signalling nan
            end else if (sign) begin
                special = `SPEC_NAN;
                invalid = 1'b1;
            end else begin
                special = `SPEC_INF;
            end
        end else if (subnormal && frac == 23'd0) begin
            special = `SPEC_ZERO; // sign kept
        end else if (sign) begin
            special = `SPEC_NAN;
            invalid = 1'b1;
        end
    end

    assign in_ready = ~u_valid | u_ready;
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            u_valid <= 1'b0;
        end else if (load) begin
            u_valid <= 1'b1;
        end else if (u_ready) begin
            u_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            u_rad     <= {sig_even, {(2*`ROOT_BITS-25){1'b0}}};
            u_exp     <= exp_unb >>> 1; // floor halves odd exponents
            u_sign    <= sign;
            u_special <= special;
            u_invalid <= invalid;
            u_dest    <= in_dest;
        end
    end

    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        u_valid && !u_ready |=> u_valid);

endmodule

//--- design/sqrt_iterate.sv
`timescale 1ns/1ps

`include "sqrt_consts.svh"

module sqrt_iterate
    import sqrt_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     u_valid,
    output logic     u_ready,
    input  rad_t     u_rad,
    input  exp_t     u_exp,
    input  logic     u_sign,
    input  special_t u_special,
    input  logic     u_invalid,
    input  dest_t    u_dest,

    output logic     r_valid,
    input  logic     r_ready,
    output root_t    r_root,
    output logic     r_sticky,
    output exp_t     r_exp,
    output logic     r_sign,
    output special_t r_special,
    output logic     r_invalid,
    output dest_t    r_dest
);

    localparam int CNT_W = $clog2(`ROOT_BITS + 1);

    iter_state_t              state;
    logic [CNT_W-1:0]         count;
    rad_t                     rad_q;
    root_t                    root_q;
    logic [`ROOT_BITS+1:0]    rem_q;

    logic                     load;
    logic                     step;
    rad_t                     rad_src;
    root_t                    root_in;
    logic [`ROOT_BITS+1:0]    rem_in;
    logic [`ROOT_BITS+3:0]    rem_shift;
    logic [`ROOT_BITS+3:0]    trial;
    logic [`ROOT_BITS+3:0]    rem_diff;
    logic                     ge;
    logic [`ROOT_BITS+1:0]    rem_next;
    root_t                    root_next;

    assign u_ready = (state == iter_idle) | ((state == iter_done) & r_ready);
    assign load    = u_valid & u_ready;
    assign step    = (state == iter_busy);

    // first root bit is taken in the load cycle
    assign rad_src   = load ? u_rad : rad_q;
    assign root_in   = load ? '0 : root_q;
    assign rem_in    = load ? '0 : rem_q;
    assign rem_shift = {rem_in, rad_src[2*`ROOT_BITS-1 -: 2]};
    assign trial     = {2'b00, root_in, 2'b01};
    assign rem_diff  = rem_shift - trial;
    assign ge        = (rem_shift >= trial);
    assign rem_next  = ge ? rem_diff[`ROOT_BITS+1:0] : rem_shift[`ROOT_BITS+1:0];
    assign root_next = {root_in[`ROOT_BITS-2:0], ge};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= iter_idle;
            count <= '0;
        end else begin
            case (state)
                iter_idle: begin
                    if (load) begin
                        state <= iter_busy;
                        count <= CNT_W'(1);
                    end
                end
                iter_busy: begin
                    count <= count + CNT_W'(1);
                    if (count == CNT_W'(`ROOT_BITS - 1)) state <= iter_done;
                end
                iter_done: begin
                    if (load) begin // back to back
                        state <= iter_busy;
                        count <= CNT_W'(1);
                    end else if (r_ready) begin
                        state <= iter_idle;
                    end
                end
                default: state <= iter_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load || step) begin
            rem_q  <= rem_next;
            root_q <= root_next;
            rad_q  <= rad_src << 2;
        end
        if (load) begin
            r_exp     <= u_exp;
            r_sign    <= u_sign;
            r_special <= u_special;
            r_invalid <= u_invalid;
            r_dest    <= u_dest;
        end
    end

    assign r_valid  = (state == iter_done);
    assign r_root   = root_q;
    assign r_sticky = |rem_q; // anything left below the round bit

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(`ROOT_BITS));

endmodule

//--- design/sqrt_normalize.sv
`timescale 1ns/1ps

`include "sqrt_consts.svh"

module sqrt_normalize
    import sqrt_pkg::*;
#(
    parameter int OUTPUT_REGISTER = 1
)(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     r_valid,
    output logic     r_ready,
    input  root_t    r_root,
    input  logic     r_sticky,
    input  exp_t     r_exp,
    input  logic     r_sign,
    input  special_t r_special,
    input  logic     r_invalid,
    input  dest_t    r_dest,

    output logic     out_valid,
    input  logic     out_ready,
    output float_t   out_result,
    output dest_t    out_dest,
    output logic     out_invalid,
    output logic     out_inexact
);

    logic        lsb;
    logic        guard;
    logic        round_bit;
    logic        round_up;
    logic [24:0] sum;
    logic [7:0]  exp_biased;
    float_t      result;
    logic        inexact;

    assign lsb       = r_root[2];
    assign guard     = r_root[1];
    assign round_bit = r_root[0];
    assign round_up  = guard & (round_bit | r_sticky | lsb); // nearest even

    assign sum        = {1'b0, r_root[`ROOT_BITS-1:2]} + 25'(round_up);
    assign exp_biased = 8'(r_exp + exp_t'(`EXP_BIAS) + exp_t'(sum[24])); // carry bumps exp

    always_comb begin
        inexact = 1'b0;
        case (r_special)
            `SPEC_NAN:  result = `FLOAT_QNAN;
            `SPEC_INF:  result = `FLOAT_PINF;
            `SPEC_ZERO: result = {r_sign, {(`FLOAT_WIDTH-1){1'b0}}};
            default: begin
                result  = {r_sign, exp_biased, sum[22:0]}; // fraction is zero on carry
                inexact = guard | round_bit | r_sticky;
            end
        endcase
    end

    generate
        if (OUTPUT_REGISTER != 0) begin : g_reg
            assign r_ready = ~out_valid | out_ready;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    out_valid <= 1'b0;
                end else if (r_ready) begin
                    out_valid <= r_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (r_valid && r_ready) begin
                    out_result  <= result;
                    out_dest    <= r_dest;
                    out_invalid <= r_invalid;
                    out_inexact <= inexact;
                end
            end
        end else begin : g_pass
            assign r_ready     = out_ready;
            assign out_valid   = r_valid;
            assign out_result  = result;
            assign out_dest    = r_dest;
            assign out_invalid = r_invalid;
            assign out_inexact = inexact;
        end
    endgenerate

    a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_result));

endmodule

//--- design/sqrt_unit.sv
`timescale 1ns/1ps

module sqrt_unit
    import sqrt_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    input  logic   in_valid,
    output logic   in_ready,
    input  float_t in_operand,
    input  dest_t  in_dest,

    output logic   out_valid,
    input  logic   out_ready,
    output float_t out_result,
    output dest_t  out_dest,
    output logic   out_invalid,
    output logic   out_inexact
);

    logic     u_valid;
    logic     u_ready;
    rad_t     u_rad;
    exp_t     u_exp;
    logic     u_sign;
    special_t u_special;
    logic     u_invalid;
    dest_t    u_dest;

    logic     r_valid;
    logic     r_ready;
    root_t    r_root;
    logic     r_sticky;
    exp_t     r_exp;
    logic     r_sign;
    special_t r_special;
    logic     r_invalid;
    dest_t    r_dest;

    sqrt_unpack unpack_inst (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_operand, .in_dest,
        .u_valid, .u_ready, .u_rad, .u_exp, .u_sign, .u_special, .u_invalid, .u_dest
    );

    sqrt_iterate iterate_inst (
        .clk, .rst_n,
        .u_valid, .u_ready, .u_rad, .u_exp, .u_sign, .u_special, .u_invalid, .u_dest,
        .r_valid, .r_ready, .r_root, .r_sticky, .r_exp, .r_sign, .r_special,
        .r_invalid, .r_dest
    );

    sqrt_normalize #(
        .OUTPUT_REGISTER(1)
    ) normalize_inst (
        .clk, .rst_n,
        .r_valid, .r_ready, .r_root, .r_sticky, .r_exp, .r_sign, .r_special,
        .r_invalid, .r_dest,
        .out_valid, .out_ready, .out_result, .out_dest, .out_invalid, .out_inexact
    );

endmodule

//--- testbench/sqrt_unit_tb.sv
`timescale 1ns/1ps

`include "sqrt_consts.svh"

module sqrt_unit_tb
    import sqrt_pkg::*;
();

    localparam int N_TABLE        = 15;
    localparam int N_RANDOM       = 40;
    localparam int N_TOTAL        = N_TABLE + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 60 + 100;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    float_t in_operand;
    dest_t  in_dest;
    logic   out_valid;
    logic   out_ready;
    float_t out_result;
    dest_t  out_dest;
    logic   out_invalid;
    logic   out_inexact;

    float_t tab_operand [N_TOTAL];
    dest_t  tab_dest    [N_TOTAL];
    float_t tab_result  [N_TOTAL];
    logic   tab_invalid [N_TOTAL];
    logic   tab_inexact [N_TOTAL];

    int     exp_q[$]; // table indices in flight
    integer seed;
    int     n_entries;
    int     drive_index;
    int     received;
    int     errors;
    int     cycles;
    int     gap;
    int     idx;
    int     k;
    logic   seen_input;
    logic   reset_seen;

    sqrt_unit DUT (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_operand, .in_dest,
        .out_valid, .out_ready, .out_result, .out_dest, .out_invalid, .out_inexact
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // integer to binary32 conversion is exact below 2**24
    function automatic float_t int_to_float(input int unsigned v);
        int          msb;
        logic [31:0] norm;
        msb = -1;
        for (int b = 0; b < 32; b++) begin
            if (v[b]) msb = b; // leading one search
        end
        if (msb < 0) return '0;
        norm = v << (31 - msb);
        return {1'b0, 8'(`EXP_BIAS + msb), norm[30:8]};
    endfunction

    task automatic add_entry(input float_t operand, input float_t result,
                             input logic invalid, input logic inexact);
        tab_operand[n_entries] = operand;
        tab_dest[n_entries]    = dest_t'($random(seed));
        tab_result[n_entries]  = result;
        tab_invalid[n_entries] = invalid;
        tab_inexact[n_entries] = inexact;
        n_entries++;
    endtask

    task automatic check_output(input int i);
        assert (out_result == tab_result[i]) else begin
            $display("Fail at %0t: out_result expected %h, got %h", $time, tab_result[i],
                     out_result);
            errors++;
        end
        assert (out_dest == tab_dest[i]) else begin
            $display("Fail at %0t: out_dest expected %0d, got %0d", $time, tab_dest[i],
                     out_dest);
            errors++;
        end
        assert (out_invalid == tab_invalid[i]) else begin
            $display("Fail at %0t: out_invalid expected %b, got %b", $time, tab_invalid[i],
                     out_invalid);
            errors++;
        end
        assert (out_inexact == tab_inexact[i]) else begin
            $display("Fail at %0t: out_inexact expected %b, got %b", $time, tab_inexact[i],
                     out_inexact);
            errors++;
        end
    endtask

    // scoreboard sampled on the rising edge
    always @(posedge clk) begin
        assert (!reset_seen || seen_input || out_valid === 1'b0) else begin
            $display("out_valid was not low at %0t before any operand was accepted", $time);
            errors++;
        end
        if (!rst_n) reset_seen = 1'b1;
        if (rst_n && in_valid && in_ready) begin
            exp_q.push_back(drive_index);
            seen_input = 1'b1;
        end
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("result at %0t arrived with no operand outstanding", $time);
                errors++;
            end else begin
                idx = exp_q.pop_front();
                check_output(idx);
                received++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            out_ready <= ($random(seed) & 3) != 0; // stall about one cycle in four
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d results received",
                 cycles, received, n_entries);
        $display("errors: %0d, results checked: %0d", errors + 1, received);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed        = 32'h263c;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_operand  = '0;
        in_dest     = '0;
        out_ready   = 1'b0;
        n_entries   = 0;
        drive_index = 0;
        received    = 0;
        errors      = 0;
        seen_input  = 1'b0;
        reset_seen  = 1'b0;

        add_entry(32'h3F800000, 32'h3F800000, 1'b0, 1'b0); // 1.0
        add_entry(32'h40800000, 32'h40000000, 1'b0, 1'b0); // 4.0
        add_entry(32'h3E800000, 32'h3F000000, 1'b0, 1'b0); // 0.25
        add_entry(32'h40000000, 32'h3FB504F3, 1'b0, 1'b1); // sqrt 2
        add_entry(32'h00000001, 32'h1A3504F3, 1'b0, 1'b1); // smallest subnormal
        add_entry(32'h41100000, 32'h40400000, 1'b0, 1'b0);
        add_entry(32'h41800000, 32'h40800000, 1'b0, 1'b0);
        add_entry(32'h00000000, 32'h00000000, 1'b0, 1'b0);
        add_entry(32'h80000000, 32'h80000000, 1'b0, 1'b0); // -0 stays -0
        add_entry(32'h7F800000, `FLOAT_PINF, 1'b0, 1'b0);
        add_entry(32'hC0800000, `FLOAT_QNAN, 1'b1, 1'b0);
        add_entry(32'hBF800000, `FLOAT_QNAN, 1'b1, 1'b0);
        add_entry(32'hFF800000, `FLOAT_QNAN, 1'b1, 1'b0); // -inf
        add_entry(32'h7F800001, `FLOAT_QNAN, 1'b1, 1'b0); // signalling nan
        add_entry(32'h7FC00000, `FLOAT_QNAN, 1'b0, 1'b0);
        for (int r = 0; r < N_RANDOM; r++) begin
            k = int'($unsigned($random(seed)) % 4095) + 1;
            add_entry(int_to_float(k * k), int_to_float(k), 1'b0, 1'b0);
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_entries; i++) begin
            gap = int'($unsigned($random(seed)) % 3);
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid    <= 1'b1;
            in_operand  <= tab_operand[i];
            in_dest     <= tab_dest[i];
            drive_index <= i;
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        in_valid <= 1'b0;

        wait (received == n_entries);
        repeat (40) @(posedge clk); // catch any extra results

        $display("errors: %0d, results checked: %0d of %0d", errors, received, n_entries);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/sqrt_pkg.sv
design/sqrt_unpack.sv
design/sqrt_iterate.sv
design/sqrt_normalize.sv
design/sqrt_unit.sv
testbench/sqrt_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module sqrt_unit_tb -o sim_sqrt_unit \
    || { echo "build failed"; exit 1; }
result=$(./obj_dir/sim_sqrt_unit)
echo "$result"
echo "$result" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
